// ==== Makefile ====
# Verilator build and run for the adc capture front end

VERILATOR ?= verilator
TOP       ?= tb_adcfifo
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/adcfifo_top.sv ====
// adc capture front end top
// registers, capture control, packer, shared buffer and drain
`timescale 1ns/1ps

module adcfifo_top (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic                        reg_wr,
  input  logic                        reg_rd,
  input  capture_cfg_pkg::reg_addr_t  reg_addr,
  input  capture_cfg_pkg::reg_word_t  reg_wdata,
  output logic                        reg_rvalid,
  output capture_cfg_pkg::reg_word_t  reg_rdata,
  input  logic                        xfer_req,
  input  logic                        dac_ack,
  output logic                        dac_tx,
  output logic                        rxq_sw_ctl,
  input  logic                        adc_wr,
  input  capture_data_pkg::adc_word_t adc_wdata,
  input  logic                        dma_en,
  output logic                        dma_wr,
  output capture_data_pkg::buf_word_t dma_wdata
);

  logic                        txrx_en;
  logic                        meas_noise;
  logic                        search;
  capture_cfg_pkg::noise_pd_t  noise_half_pd;
  logic                        capturing;
  logic                        go_pulse;
  logic                        ovf_evt;
  logic                        wr_en;
  capture_data_pkg::buf_ptr_t  wr_addr;
  capture_data_pkg::buf_word_t wr_data;
  capture_data_pkg::buf_ptr_t  wr_ptr;
  capture_data_pkg::buf_ptr_t  rd_ptr;
  logic                        rd_req;
  capture_data_pkg::buf_ptr_t  rd_addr;
  logic                        rd_gnt;
  logic                        rd_vld;
  capture_data_pkg::buf_word_t rd_data;

  reg_file u_reg_file (
    .adc_clk, .arst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
    .reg_rvalid, .reg_rdata, .capturing, .go_pulse, .ovf_evt,
    .txrx_en, .meas_noise, .search, .noise_half_pd
  );

  capture_ctrl u_capture_ctrl (
    .adc_clk, .arst_n, .xfer_req, .dac_ack, .txrx_en, .meas_noise, .search,
    .noise_half_pd, .dac_tx, .capturing, .go_pulse, .rxq_sw_ctl
  );

  word_packer u_word_packer (
    .adc_clk, .arst_n, .capturing, .adc_wr, .adc_wdata, .rd_ptr,
    .wr_en, .wr_addr, .wr_data, .wr_ptr, .ovf_evt
  );

  buf_arbiter u_buf_arbiter (
    .adc_clk, .arst_n, .wr_en, .wr_addr, .wr_data,
    .rd_req, .rd_addr, .rd_gnt, .rd_vld, .rd_data
  );

  buf_drain u_buf_drain (
    .adc_clk, .arst_n, .dma_en, .wr_ptr, .rd_gnt, .rd_vld, .rd_data,
    .rd_req, .rd_addr, .rd_ptr, .dma_wr, .dma_wdata
  );

endmodule

// ==== hw/buf_arbiter.sv ====
// shared sample memory
// one write port and one read port, writes win a same-cycle conflict
`timescale 1ns/1ps
`include "capture_consts.svh"

module buf_arbiter (
  input  logic                        adc_clk,
  input  logic                        arst_n,

  // from the packer
  input  logic                        wr_en,
  input  capture_data_pkg::buf_ptr_t  wr_addr,
  input  capture_data_pkg::buf_word_t wr_data,

  // from the drain
  input  logic                        rd_req,
  input  capture_data_pkg::buf_ptr_t  rd_addr,
  output logic                        rd_gnt,
  output logic                        rd_vld,
  output capture_data_pkg::buf_word_t rd_data
);

  capture_data_pkg::buf_word_t mem [`BUF_DEPTH];

  // the packer can't wait, so the read is held off instead
  assign rd_gnt = rd_req && !wr_en;

  always_ff @(posedge adc_clk) begin
    if (wr_en)
      mem[wr_addr[`PTR_W-2:0]] <= wr_data;
    if (rd_gnt)
      rd_data <= mem[rd_addr[`PTR_W-2:0]];  // registered read
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n)
      rd_vld <= 1'b0;
    else
      rd_vld <= rd_gnt;
  end

  // a read held off by a write stays requested at the same slot
  a_held_on_wr: assert property (@(posedge adc_clk) disable iff (!arst_n)
    rd_req && wr_en |=> rd_req && $stable(rd_addr));

  // drain keeps only one read in flight
  a_one_in_flight: assert property (@(posedge adc_clk) disable iff (!arst_n)
    rd_gnt |=> !rd_req);

endmodule

// ==== hw/buf_drain.sv ====
// buffer drain
// owns the read pointer and forwards buffer words as dma strobes
`timescale 1ns/1ps
`include "capture_consts.svh"

module buf_drain (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic                        dma_en,
  input  capture_data_pkg::buf_ptr_t  wr_ptr,
  input  logic                        rd_gnt,
  input  logic                        rd_vld,
  input  capture_data_pkg::buf_word_t rd_data,
  output logic                        rd_req,
  output capture_data_pkg::buf_ptr_t  rd_addr,
  output capture_data_pkg::buf_ptr_t  rd_ptr,
  output logic                        dma_wr,
  output capture_data_pkg::buf_word_t dma_wdata
);

  logic in_flight;  // granted, data not back yet
  logic empty;

  assign empty   = (wr_ptr == rd_ptr);
  assign rd_req  = dma_en && !empty && !in_flight;  // held until granted
  assign rd_addr = {1'b0, rd_ptr[`PTR_W-2:0]};

  // arbiter data goes straight out
  assign dma_wr    = rd_vld;
  assign dma_wdata = rd_data;

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr    <= '0;
      in_flight <= 1'b0;
    end else if (rd_gnt) begin
      rd_ptr    <= rd_ptr + 1'b1;  // slot is free once read is registered
      in_flight <= 1'b1;
    end else if (rd_vld)
      in_flight <= 1'b0;
  end

endmodule

// ==== hw/capture_cfg_pkg.sv ====
// control side types
// register access, noise period, event counts and capture states
`include "capture_consts.svh"

package capture_cfg_pkg;

  typedef logic [`REG_AW-1:0]     reg_addr_t;
  typedef logic [`REG_DW-1:0]     reg_word_t;
  typedef logic [`NOISE_PD_W-1:0] noise_pd_t;  // half period minus one
  typedef logic [`CNT_W-1:0]      evt_cnt_t;   // wraps

  // capture go machine
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_WAIT_ACK,  // request seen, waiting on dac
    CAP_SAVING
  } cap_state_t;

endpackage

// ==== hw/capture_consts.svh ====
// capture front end constants
// widths, buffer depth, version code and register reset values
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// sample path
`define ADC_W        64      // four 16-bit samples
`define BUF_W        128     // two adc words, first one in the low half
`define BUF_DEPTH    16
`define PTR_W        5       // log2(depth) plus wrap bit

// register port
`define REG_AW       2
`define REG_DW       32

// capture control
`define SYNC_STAGES  3
`define NOISE_PD_W   11
`define NOISE_PD_RST 11'd1524
`define CNT_W        4

// reported in the status word
`define CORE_VER     8'h02

`endif

// ==== hw/capture_ctrl.sv ====
// capture go control
// syncs the transfer request and dac ack, runs the capture FSM,
// and toggles the noise measurement switch while capturing
`timescale 1ns/1ps
`include "capture_consts.svh"

module capture_ctrl (
  input  logic                       adc_clk,
  input  logic                       arst_n,
  input  logic                       xfer_req,
  input  logic                       dac_ack,
  input  logic                       txrx_en,
  input  logic                       meas_noise,
  input  logic                       search,
  input  capture_cfg_pkg::noise_pd_t noise_half_pd,
  output logic                       dac_tx,
  output logic                       capturing,
  output logic                       go_pulse,
  output logic                       rxq_sw_ctl
);

  logic [`SYNC_STAGES-1:0]     req_sync;
  logic [`SYNC_STAGES-1:0]     ack_sync;
  logic                        req_s;
  logic                        ack_s;
  capture_cfg_pkg::cap_state_t state;
  logic                        saving_d;
  logic                        noise_en;
  capture_cfg_pkg::noise_pd_t  noise_cnt;

  assign req_s = req_sync[`SYNC_STAGES-1];
  assign ack_s = ack_sync[`SYNC_STAGES-1];

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      req_sync <= '0;
      ack_sync <= '0;
      dac_tx   <= 1'b0;
    end else begin
      req_sync <= {req_sync[`SYNC_STAGES-2:0], xfer_req};
      ack_sync <= {ack_sync[`SYNC_STAGES-2:0], dac_ack};
      dac_tx   <= req_s;  // ask the dac for headers
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= capture_cfg_pkg::CAP_IDLE;
      saving_d <= 1'b0;
    end else begin
      saving_d <= capturing;
      if (!txrx_en)
        state <= capture_cfg_pkg::CAP_IDLE;
      else begin
        case (state)
          capture_cfg_pkg::CAP_IDLE:
            if (req_s)
              state <= search ? capture_cfg_pkg::CAP_SAVING : capture_cfg_pkg::CAP_WAIT_ACK;
          capture_cfg_pkg::CAP_WAIT_ACK:
            if (ack_s)
              state <= capture_cfg_pkg::CAP_SAVING;
          // request may drop now, keep saving until txrx_en goes away
          capture_cfg_pkg::CAP_SAVING: state <= capture_cfg_pkg::CAP_SAVING;
          default:                     state <= capture_cfg_pkg::CAP_IDLE;
        endcase
      end
    end
  end

  assign capturing = (state == capture_cfg_pkg::CAP_SAVING);
  assign go_pulse  = capturing && !saving_d;

  // txrx_en term clears the switch on the same edge that capture stops
  assign noise_en = capturing && meas_noise && txrx_en;

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      noise_cnt  <= '0;
      rxq_sw_ctl <= 1'b0;
    end else if (!noise_en) begin
      noise_cnt  <= noise_half_pd;
      rxq_sw_ctl <= 1'b0;
    end else if (noise_cnt == '0) begin
      noise_cnt  <= noise_half_pd;  // half_pd+1 cycles per level
      rxq_sw_ctl <= ~rxq_sw_ctl;
    end else
      noise_cnt <= noise_cnt - 1'b1;
  end

  // go only on a legal entry into saving
  a_go_on_entry: assert property (@(posedge adc_clk) disable iff (!arst_n)
    go_pulse |-> $past(txrx_en) &&
                 (($past(state) == capture_cfg_pkg::CAP_WAIT_ACK && $past(ack_s)) ||
                  ($past(state) == capture_cfg_pkg::CAP_IDLE && $past(req_s && search))));

  a_sw_idle_low: assert property (@(posedge adc_clk) disable iff (!arst_n)
    !capturing |-> !rxq_sw_ctl);

endmodule

// ==== hw/capture_data_pkg.sv ====
// data side types
// adc words, packed buffer words and buffer pointers
`include "capture_consts.svh"

package capture_data_pkg;

  typedef logic [`ADC_W-1:0] adc_word_t;
  typedef logic [`BUF_W-1:0] buf_word_t;

  // msb is the wrap bit, low bits address the memory
  typedef logic [`PTR_W-1:0] buf_ptr_t;

endpackage

// ==== hw/reg_file.sv ====
// control and status registers
// also keeps the capture start count and the sticky overflow flag
`timescale 1ns/1ps
`include "capture_consts.svh"

module reg_file (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic                        reg_wr,
  input  logic                        reg_rd,
  input  capture_cfg_pkg::reg_addr_t  reg_addr,
  input  capture_cfg_pkg::reg_word_t  reg_wdata,
  output logic                        reg_rvalid,
  output capture_cfg_pkg::reg_word_t  reg_rdata,
  input  logic                        capturing,
  input  logic                        go_pulse,
  input  logic                        ovf_evt,
  output logic                        txrx_en,
  output logic                        meas_noise,
  output logic                        search,
  output capture_cfg_pkg::noise_pd_t  noise_half_pd
);

  logic [3:0]                 ctrl_q;     // clr_cnts, search, meas_noise, txrx_en
  logic                       clr_cnts;
  capture_cfg_pkg::evt_cnt_t  start_cnt;
  logic                       ovf_flag;
  capture_cfg_pkg::reg_word_t status;
  capture_cfg_pkg::reg_word_t rd_mux;

  assign txrx_en    = ctrl_q[0];
  assign meas_noise = ctrl_q[1];
  assign search     = ctrl_q[2];
  assign clr_cnts   = ctrl_q[3];  // level, holds counts at zero

  assign status = {`CORE_VER, 16'h0000, start_cnt, 2'b00, ovf_flag, capturing};

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q        <= '0;
      noise_half_pd <= `NOISE_PD_RST;
      start_cnt     <= '0;
      ovf_flag      <= 1'b0;
      reg_rvalid    <= 1'b0;
    end else begin
      if (reg_wr && reg_addr == 2'd0)
        ctrl_q <= reg_wdata[3:0];
      if (reg_wr && reg_addr == 2'd1)
        noise_half_pd <= reg_wdata[`NOISE_PD_W-1:0];

      if (clr_cnts) begin
        start_cnt <= '0;
        ovf_flag  <= 1'b0;
      end else begin
        if (go_pulse)
          start_cnt <= start_cnt + 1'b1;  // wraps
        if (ovf_evt)
          ovf_flag <= 1'b1;  // sticky
      end

      reg_rvalid <= reg_rd;
    end
  end

  always_comb begin
    case (reg_addr)
      2'd0:    rd_mux = {{(`REG_DW-4){1'b0}}, ctrl_q};
      2'd1:    rd_mux = {{(`REG_DW-`NOISE_PD_W){1'b0}}, noise_half_pd};
      2'd2:    rd_mux = status;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reg_rd)
      reg_rdata <= rd_mux;
  end

endmodule

// ==== hw/word_packer.sv ====
// adc word packer
// pairs adc words into buffer words, owns the write pointer, drops on full
`timescale 1ns/1ps
`include "capture_consts.svh"

module word_packer (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic                        capturing,
  input  logic                        adc_wr,
  input  capture_data_pkg::adc_word_t adc_wdata,
  input  capture_data_pkg::buf_ptr_t  rd_ptr,
  output logic                        wr_en,
  output capture_data_pkg::buf_ptr_t  wr_addr,
  output capture_data_pkg::buf_word_t wr_data,
  output capture_data_pkg::buf_ptr_t  wr_ptr,
  output logic                        ovf_evt
);

  logic                        phase;    // 1 = holding the first word of a pair
  capture_data_pkg::adc_word_t lo_word;
  logic                        full;

  // same slot, opposite lap
  assign full = (wr_ptr[`PTR_W-1] != rd_ptr[`PTR_W-1]) &&
                (wr_ptr[`PTR_W-2:0] == rd_ptr[`PTR_W-2:0]);
  assign wr_addr = {1'b0, wr_ptr[`PTR_W-2:0]};

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase   <= 1'b0;
      wr_en   <= 1'b0;
      ovf_evt <= 1'b0;
      wr_ptr  <= '0;
    end else begin
      wr_en   <= 1'b0;
      ovf_evt <= 1'b0;
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // bumps with the memory write
      if (!capturing)
        phase <= 1'b0;
      else if (adc_wr) begin
        phase <= ~phase;
        if (phase) begin
          if (full)
            ovf_evt <= 1'b1;
          else
            wr_en <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (capturing && adc_wr) begin
      if (!phase)
        lo_word <= adc_wdata;
      else
        wr_data <= {adc_wdata, lo_word};  // first word low
    end
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/capture_cfg_pkg.sv
hw/capture_data_pkg.sv
hw/reg_file.sv
hw/capture_ctrl.sv
hw/word_packer.sv
hw/buf_arbiter.sv
hw/buf_drain.sv
hw/adcfifo_top.sv
tests/tb_adcfifo.sv

// ==== tests/capture_vectors.txt ====
// op a b c in hex: 1 wr(addr,data) 2 rd(addr,exp,mask) 3 pins(b0 req,b1 ack,b2 dma_en) 4 idle(n)
// 5 burst(words,store) 6 drain(limit) 7 pin(0 dac_tx|1 rxq_sw_ctl,exp) 8 noise(gap,n) 9 end(test)
2 0 00000000 ffffffff
2 1 000005f4 ffffffff   // half period 1524
2 2 02000000 ffffffff
2 3 00000000 ffffffff
1 1 00000123 0
2 1 00000123 ffffffff
1 0 00000006 0          // meas_noise and search, capture still off
2 0 00000006 ffffffff
1 0 00000000 0
9 1 0 0
1 0 00000001 0          // txrx_en, search off
3 1 0 0
4 8 0 0
7 0 1 0
2 2 02000000 ffffffff   // waiting for ack
3 3 0 0
4 8 0 0
2 2 02000011 ffffffff
3 0 0 0                 // request and ack drop, capture holds
4 8 0 0
7 0 0 0
2 2 02000011 ffffffff
1 0 00000000 0
2 2 02000010 ffffffff
9 2 0 0
1 0 00000005 0          // txrx_en and search
3 5 0 0                 // request with dma on, no ack
4 6 0 0
2 2 02000021 ffffffff
5 10 1 0                // 16 words
6 c8 0 0
5 0a 1 0
6 c8 0 0
4 10 0 0
1 0 00000000 0
9 3 0 0
3 1 0 0                 // dma off
1 0 00000005 0
4 6 0 0
2 2 02000031 ffffffff
5 28 1 0                // 40 words into a 16 deep buffer
4 4 0 0
2 2 02000033 ffffffff
3 5 0 0
6 c8 0 0
4 10 0 0
1 0 00000008 0          // clr_cnts
2 2 02000000 ffffffff
1 0 00000000 0
9 4 0 0
1 1 00000009 0
1 0 00000007 0          // txrx_en, meas_noise, search
4 4 0 0
2 2 02000011 ffffffff
8 a 4 0                 // edges 10 cycles apart
1 0 00000000 0
4 2 0 0
7 1 0 0
9 5 0 0

// ==== tests/tb_adcfifo.sv ====
// testbench for the adc capture front end
// replays command vectors from a file, models the buffer and checks dma output
`timescale 1ns/1ps
`include "capture_consts.svh"

module tb_adcfifo;

  localparam int MAX_WORDS = 512;  // four words per command
  localparam int CLK_HALF  = 50;

  logic                        adc_clk;
  logic                        arst_n;
  logic                        reg_wr;
  logic                        reg_rd;
  capture_cfg_pkg::reg_addr_t  reg_addr;
  capture_cfg_pkg::reg_word_t  reg_wdata;
  logic                        reg_rvalid;
  capture_cfg_pkg::reg_word_t  reg_rdata;
  logic                        xfer_req;
  logic                        dac_ack;
  logic                        dac_tx;
  logic                        rxq_sw_ctl;
  logic                        adc_wr;
  capture_data_pkg::adc_word_t adc_wdata;
  logic                        dma_en;
  logic                        dma_wr;
  capture_data_pkg::buf_word_t dma_wdata;

  logic [31:0]                 vec [MAX_WORDS];
  capture_data_pkg::buf_word_t model_q [$];  // every word expected on dma, in order
  int                          dma_idx = 0;  // next model entry the dma should deliver
  int                          dma_errors = 0;
  int                          errors = 0;
  int                          cycle = 0;
  int                          budget = 0;
  logic                        budget_ready = 1'b0;
  logic [15:0]                 lfsr = 16'd36997;

  adcfifo_top u_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #CLK_HALF adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) cycle <= cycle + 1;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per data bit
  task automatic next_adc_word(output capture_data_pkg::adc_word_t w);
    for (int i = 0; i < `ADC_W; i++) begin
      w[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
    errors++;
  endtask

  function automatic string test_title(input logic [31:0] n);
    case (n)
      1:       return "reset and register access";
      2:       return "acknowledged start";
      3:       return "search start and data path";
      4:       return "overflow";
      5:       return "noise switch";
      default: return "unnamed";
    endcase
  endfunction

  // cycles each command may take, for the watchdog
  function automatic int cycle_cost(input logic [31:0] op, input logic [31:0] a,
                                    input logic [31:0] b);
    case (op)
      1:       return 2;
      2:       return 6;
      3, 7:    return 1;
      4, 6:    return int'(a);
      5:       return int'(a) + 1;
      8:       return int'(a) * 4 * (int'(b) + 1) + 1;
      default: return 0;
    endcase
  endfunction

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge adc_clk);
    reg_wr    = 1'b1;
    reg_addr  = addr[1:0];
    reg_wdata = data;
    @(negedge adc_clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read_check(input logic [31:0] addr, input logic [31:0] exp,
                                input logic [31:0] mask);
    int waited = 0;
    @(negedge adc_clk);
    reg_rd   = 1'b1;
    reg_addr = addr[1:0];
    @(negedge adc_clk);
    reg_rd = 1'b0;
    while (!reg_rvalid && waited < 4) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!reg_rvalid) begin
      $display("register read at address %0d got no reply", addr);
      errors++;
    end else if ((reg_rdata & mask) !== (exp & mask))
      report_mismatch("reg_rdata", 128'(reg_rdata), 128'(exp));
  endtask

  // pairs go to the model unless the buffer would be full
  task automatic adc_burst(input int count, input logic store);
    capture_data_pkg::adc_word_t w;
    capture_data_pkg::adc_word_t first;
    for (int i = 0; i < count; i++) begin
      next_adc_word(w);
      @(negedge adc_clk);
      adc_wr    = 1'b1;
      adc_wdata = w;
      if (i % 2 == 0)
        first = w;
      else if (store && model_q.size() - dma_idx < `BUF_DEPTH)
        model_q.push_back({w, first});  // first word low
    end
    @(negedge adc_clk);
    adc_wr = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int waited = 0;
    while (dma_idx < model_q.size() && waited < limit) begin
      @(negedge adc_clk);
      waited++;
    end
    if (dma_idx < model_q.size()) begin
      $display("dma stalled with %0d words still expected", model_q.size() - dma_idx);
      errors++;
    end
  endtask

  task automatic check_noise(input int gap, input int intervals);
    logic last;
    int   t_last = -1;
    int   seen = 0;
    int   waited = 0;
    @(negedge adc_clk);
    last = rxq_sw_ctl;
    while (seen <= intervals && waited < gap * 4 * (intervals + 1)) begin
      @(negedge adc_clk);
      waited++;
      if (rxq_sw_ctl !== last) begin
        if (t_last >= 0 && cycle - t_last != gap)
          report_mismatch("rxq_sw_ctl edge gap", 128'(cycle - t_last), 128'(gap));
        last   = rxq_sw_ctl;
        t_last = cycle;
        seen++;
      end
    end
    if (seen <= intervals) begin
      $display("rxq_sw_ctl stopped toggling after %0d edges", seen);
      errors++;
    end
  endtask

  always @(negedge adc_clk) begin
    if (arst_n && dma_wr) begin
      if (dma_idx >= model_q.size()) begin
        $display("dma word %0h arrived with none expected", dma_wdata);
        dma_errors++;
      end else begin
        if (dma_wdata !== model_q[dma_idx]) begin
          $display("MISMATCH dma_wdata: got %0h expected %0h", dma_wdata, model_q[dma_idx]);
          dma_errors++;
        end
        dma_idx++;
      end
    end
  end

  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge adc_clk);
    $display("watchdog expired after %0d cycles", budget);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          err_base = 0;
    arst_n    = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    xfer_req  = 1'b0;
    dac_ack   = 1'b0;
    adc_wr    = 1'b0;
    adc_wdata = '0;
    dma_en    = 1'b0;
    foreach (vec[i]) vec[i] = '0;  // op 0 ends the list
    $readmemh("tests/capture_vectors.txt", vec);
    budget = 200;
    for (int pc = 0; pc + 3 < MAX_WORDS; pc += 4)
      budget += cycle_cost(vec[pc], vec[pc+1], vec[pc+2]);
    budget_ready = 1'b1;

    repeat (3) @(negedge adc_clk);
    arst_n = 1'b1;

    for (int pc = 0; pc + 3 < MAX_WORDS; pc += 4) begin
      op = vec[pc];
      a  = vec[pc+1];
      b  = vec[pc+2];
      c  = vec[pc+3];
      if (op == 0)
        break;
      case (op)
        1: reg_write(a, b);
        2: reg_read_check(a, b, c);
        3: begin
          @(negedge adc_clk);
          {dma_en, dac_ack, xfer_req} = a[2:0];
        end
        4: repeat (int'(a)) @(negedge adc_clk);
        5: adc_burst(int'(a), b[0]);
        6: wait_drain(int'(a));
        7: begin
          @(negedge adc_clk);
          if (a == 0 && dac_tx !== b[0])
            report_mismatch("dac_tx", 128'(dac_tx), 128'(b[0]));
          if (a == 1 && rxq_sw_ctl !== b[0])
            report_mismatch("rxq_sw_ctl", 128'(rxq_sw_ctl), 128'(b[0]));
        end
        8: check_noise(int'(a), int'(b));
        9: begin
          tests_run++;
          if (errors + dma_errors == err_base)
            $display("test %0d %s: ok", a, test_title(a));
          else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", a, test_title(a),
                     errors + dma_errors - err_base);
          end
          err_base = errors + dma_errors;
        end
        default: begin
          $display("unknown command %0h in vector file", op);
          errors++;
        end
      endcase
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + dma_errors);
    if (tests_failed == 0 && errors + dma_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
